// ==== src/mem_defs.svh ====
// Memory stage parameters
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// RAM word-address width. 10 bits give 4 KiB.
`define MEM_RAM_AW 10

// Cycles from strobe to ack. At least 1.
`define MEM_WAIT_STATES 2

// Machine-mode CSR addresses.
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC 12'h305
`define CSR_MHARTID 12'hF14
`define CSR_MISA 12'h301

// Read-only CSR contents.
// RV32I base with MXL = 1.
`define MISA_VALUE 32'h4000_0100
`define MHARTID_VALUE 32'h0000_0000

`endif

// ==== src/mem_pkg.sv ====
// Memory stage types
package mem_pkg;

    // Major opcode, instruction bits 6:2.
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_STORE  = 5'b01000,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    // Access size from funct3 bits 1:0.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2,
        SZ_BAD  = 2'd3
    } asize_e;

    // CSR operation from funct3 bits 1:0.
    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_e;

    // Causes raised in this stage.
    typedef enum logic [3:0] {
        CAUSE_ILLEGAL = 4'd2,
        CAUSE_LALIGN  = 4'd4,
        CAUSE_SALIGN  = 4'd6
    } trap_cause_e;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_WAIT,
        RAM_ACK
    } ram_state_e;

endpackage

// ==== src/csr_file.sv ====
// Machine-mode CSR block
`timescale 1ns/1ps
`include "mem_defs.svh"

module csr_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] csr_addr,
    input  logic        csr_we,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    output logic        csr_exists,
    output logic        csr_rdonly
);

    logic [31:0] mscratch;
    logic [31:0] mtvec;

    // Read port and address decode.
    always_comb begin
        csr_rdata  = 32'd0;
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        case (csr_addr)
            `CSR_MSCRATCH: csr_rdata = mscratch;
            `CSR_MTVEC:    csr_rdata = mtvec;
            `CSR_MHARTID: begin
                csr_rdata  = `MHARTID_VALUE;
                csr_rdonly = 1'b1;
            end
            `CSR_MISA: begin
                csr_rdata  = `MISA_VALUE;
                csr_rdonly = 1'b1;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    // Writable registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= 32'd0;
            mtvec    <= 32'd0;
        end else if (csr_we) begin
            case (csr_addr)
                `CSR_MSCRATCH: mscratch <= csr_wdata;
                // Direct mode only.
                `CSR_MTVEC:    mtvec <= {csr_wdata[31:2], 2'b00};
                default: ;
            endcase
        end
    end

endmodule

// ==== src/lsu_wb.sv ====
// Load/store unit with Wishbone master
`timescale 1ns/1ps

module lsu_wb import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,

    // Request from the stage.
    input  logic        req,
    input  logic        we,
    input  asize_e      asize,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        unsigned_ld,
    output logic        ealign,
    output logic        done,
    output logic [31:0] rdata,

    // Wishbone classic master.
    output logic        cyc,
    output logic        stb,
    output logic        wbwe,
    output logic [3:0]  sel,
    output logic [31:2] adr,
    output logic [31:0] dat_w,
    input  logic        ack,
    input  logic [31:0] dat_r
);

    logic       active;
    logic       start;
    logic [7:0] lane_byte;
    logic [15:0] lane_half;

    // Alignment check.
    always_comb begin
        case (asize)
            SZ_BYTE: ealign = 1'b0;
            SZ_HALF: ealign = addr[0];
            SZ_WORD: ealign = addr[1:0] != 2'b00;
            default: ealign = 1'b1;
        endcase
    end

    // Byte lanes and replicated store data.
    always_comb begin
        case (asize)
            SZ_BYTE: begin
                sel   = 4'b0001 << addr[1:0];
                dat_w = {4{wdata[7:0]}};
            end
            SZ_HALF: begin
                sel   = addr[1] ? 4'b1100 : 4'b0011;
                dat_w = {2{wdata[15:0]}};
            end
            SZ_WORD: begin
                sel   = 4'b1111;
                dat_w = wdata;
            end
            default: begin
                sel   = 4'b0000;
                dat_w = wdata;
            end
        endcase
    end

    assign start = req && !ealign;

    // Cycle in progress until ack or clear.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            active <= 1'b0;
        end else if (ack) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end
    end

    assign cyc  = (active || start) && !clear;
    assign stb  = cyc;
    assign wbwe = we;
    assign adr  = addr[31:2];

    // Only an ack inside our own cycle counts.
    assign done = ack && cyc;

    // Load lane select and extension.
    assign lane_byte = dat_r[{addr[1:0], 3'b000} +: 8];
    assign lane_half = addr[1] ? dat_r[31:16] : dat_r[15:0];

    always_comb begin
        case (asize)
            SZ_BYTE: rdata = {{24{!unsigned_ld && lane_byte[7]}}, lane_byte};
            SZ_HALF: rdata = {{16{!unsigned_ld && lane_half[15]}}, lane_half};
            default: rdata = dat_r;
        endcase
    end

endmodule

// ==== src/wb_ram.sv ====
// Wishbone classic RAM
`timescale 1ns/1ps

module wb_ram import mem_pkg::*; #(
    parameter int ADDR_WIDTH  = 10,
    // Must be 1 or more.
    parameter int WAIT_STATES = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [3:0]            sel,
    input  logic [ADDR_WIDTH-1:0] adr,
    input  logic [31:0]           dat_w,
    output logic                  ack,
    output logic [31:0]           dat_r
);

    localparam int CNT_W = $clog2(WAIT_STATES + 1);

    logic [31:0]   mem [2**ADDR_WIDTH];
    ram_state_e    state;
    logic [CNT_W-1:0] cnt;

    // Wait-state counter; WAIT covers the cycles between strobe and ack.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RAM_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (cyc && stb) begin
                        cnt   <= CNT_W'(1);
                        state <= (WAIT_STATES > 1) ? RAM_WAIT : RAM_ACK;
                    end
                end
                RAM_WAIT: begin
                    if (!(cyc && stb)) begin
                        state <= RAM_IDLE;
                    end else if (cnt == CNT_W'(WAIT_STATES - 1)) begin
                        state <= RAM_ACK;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RAM_IDLE;
            endcase
        end
    end

    // Read data is loaded on entry to ACK; writes land at the end of ACK.
    always_ff @(posedge clk) begin
        if (state != RAM_ACK) begin
            dat_r <= mem[adr];
        end
        if (state == RAM_ACK && cyc && stb && we) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    mem[adr][8*i +: 8] <= dat_w[8*i +: 8];
                end
            end
        end
    end

    assign ack = state == RAM_ACK;

endmodule

// ==== src/mem_stage.sv ====
// Memory and CSR access stage
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,

    // EX/MEM side.
    input  logic        d_valid,
    input  logic [31:1] d_pc,
    input  logic [31:0] d_insn,
    input  logic        d_use_rd,
    input  logic [31:0] d_rs1_val,
    input  logic [31:0] d_rs2_val,
    input  logic        d_trap,
    input  logic [3:0]  d_cause,

    // MEM/WB side.
    output logic        q_valid,
    output logic [31:1] q_pc,
    output logic [31:0] q_insn,
    output logic        q_use_rd,
    output logic [31:0] q_rd_val,
    output logic        q_trap,
    output logic [3:0]  q_cause,
    output logic        stall_req,

    // Load/store unit.
    output logic        req,
    output logic        we,
    output asize_e      asize,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    output logic        unsigned_ld,
    input  logic        ealign,
    input  logic        done,
    input  logic [31:0] rdata,

    // CSR block.
    output logic [11:0] csr_addr,
    output logic        csr_we,
    output logic [31:0] csr_wdata,
    input  logic [31:0] csr_rdata,
    input  logic        csr_exists,
    input  logic        csr_rdonly
);

    logic        r_valid;
    logic [31:1] r_pc;
    logic [31:0] r_insn;
    logic        r_use_rd;
    logic [31:0] r_rs1_val;
    logic [31:0] r_rs2_val;
    logic        r_trap;
    logic [3:0]  r_cause;

    opcode_e     opcode;
    csr_op_e     csr_op;
    logic        is_load;
    logic        is_store;
    logic        is_csr;
    logic        csr_wr_req;
    logic [31:0] csr_operand;
    logic        misalign;
    logic        illegal;
    logic        trap;
    logic [3:0]  cause;

    // Barrier register; control state is cleared by reset and by clear.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            r_valid <= 1'b0;
            r_trap  <= 1'b0;
        end else if (!stall_req) begin
            r_valid <= d_valid;
            r_trap  <= d_trap;
        end
        if (!stall_req) begin
            r_pc      <= d_pc;
            r_insn    <= d_insn;
            r_use_rd  <= d_use_rd;
            r_rs1_val <= d_rs1_val;
            r_rs2_val <= d_rs2_val;
            r_cause   <= d_cause;
        end
    end

    // Decode of the registered instruction.
    assign opcode   = opcode_e'(r_insn[6:2]);
    assign csr_op   = csr_op_e'(r_insn[13:12]);
    assign is_load  = r_valid && opcode == OP_LOAD;
    assign is_store = r_valid && opcode == OP_STORE;
    assign is_csr   = r_valid && opcode == OP_SYSTEM && csr_op != CSR_NONE;

    // No memory request for an upstream trap.
    assign req         = (is_load || is_store) && !r_trap;
    assign we          = is_store;
    assign asize       = asize_e'(r_insn[13:12]);
    assign addr        = r_rs1_val;
    assign wdata       = r_rs2_val;
    assign unsigned_ld = r_insn[14];

    // Busy until the bus cycle is acked.
    assign stall_req = req && !ealign && !done && !clear;

    // CSR operand is uimm for the immediate forms.
    assign csr_addr    = r_insn[31:20];
    assign csr_operand = r_insn[14] ? {27'd0, r_insn[19:15]} : r_rs1_val;
    // RS and RC with x0 or zero uimm only read.
    assign csr_wr_req  = is_csr && (csr_op == CSR_RW || r_insn[19:15] != 5'd0);

    always_comb begin
        case (csr_op)
            CSR_RW:  csr_wdata = csr_operand;
            CSR_RS:  csr_wdata = csr_rdata | csr_operand;
            CSR_RC:  csr_wdata = csr_rdata & ~csr_operand;
            default: csr_wdata = csr_rdata;
        endcase
    end

    // SZ_BAD is also flagged by the LSU but reported as illegal.
    assign misalign = req && ealign && asize != SZ_BAD;
    assign illegal  = (is_csr && (!csr_exists || (csr_wr_req && csr_rdonly)))
                    || (req && asize == SZ_BAD);
    assign trap     = r_trap || misalign || illegal;

    always_comb begin
        if (r_trap) begin
            cause = r_cause;
        end else if (misalign) begin
            cause = is_store ? CAUSE_SALIGN : CAUSE_LALIGN;
        end else if (illegal) begin
            cause = CAUSE_ILLEGAL;
        end else begin
            cause = 4'd0;
        end
    end

    assign csr_we = csr_wr_req && !trap && !clear;

    // Outputs to MEM/WB.
    assign q_valid  = r_valid && !trap && !stall_req && !clear;
    assign q_trap   = trap && !clear;
    assign q_cause  = cause;
    assign q_pc     = r_pc;
    assign q_insn   = r_insn;
    assign q_use_rd = r_use_rd;

    always_comb begin
        if (is_load) begin
            q_rd_val = rdata;
        end else if (is_csr) begin
            q_rd_val = csr_rdata;
        end else begin
            q_rd_val = r_rs1_val;
        end
    end

endmodule

// ==== src/mem_subsys.sv ====
// Memory stage subsystem
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,

    input  logic        d_valid,
    input  logic [31:1] d_pc,
    input  logic [31:0] d_insn,
    input  logic        d_use_rd,
    input  logic [31:0] d_rs1_val,
    input  logic [31:0] d_rs2_val,
    input  logic        d_trap,
    input  logic [3:0]  d_cause,

    output logic        q_valid,
    output logic [31:1] q_pc,
    output logic [31:0] q_insn,
    output logic        q_use_rd,
    output logic [31:0] q_rd_val,
    output logic        q_trap,
    output logic [3:0]  q_cause,
    output logic        stall_req
);

    // Stage to LSU.
    logic        mem_req;
    logic        mem_we;
    asize_e      mem_asize;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_unsigned;
    logic        mem_ealign;
    logic        mem_done;
    logic [31:0] mem_rdata;

    // Stage to CSR block.
    logic [11:0] csr_addr;
    logic        csr_we;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        csr_exists;
    logic        csr_rdonly;

    // Wishbone data bus.
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:2] wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;

    mem_stage mem_stage_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_insn     (d_insn),
        .d_use_rd   (d_use_rd),
        .d_rs1_val  (d_rs1_val),
        .d_rs2_val  (d_rs2_val),
        .d_trap     (d_trap),
        .d_cause    (d_cause),
        .q_valid    (q_valid),
        .q_pc       (q_pc),
        .q_insn     (q_insn),
        .q_use_rd   (q_use_rd),
        .q_rd_val   (q_rd_val),
        .q_trap     (q_trap),
        .q_cause    (q_cause),
        .stall_req  (stall_req),
        .req        (mem_req),
        .we         (mem_we),
        .asize      (mem_asize),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .unsigned_ld(mem_unsigned),
        .ealign     (mem_ealign),
        .done       (mem_done),
        .rdata      (mem_rdata),
        .csr_addr   (csr_addr),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .csr_exists (csr_exists),
        .csr_rdonly (csr_rdonly)
    );

    lsu_wb lsu_wb_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .req        (mem_req),
        .we         (mem_we),
        .asize      (mem_asize),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .unsigned_ld(mem_unsigned),
        .ealign     (mem_ealign),
        .done       (mem_done),
        .rdata      (mem_rdata),
        .cyc        (wb_cyc),
        .stb        (wb_stb),
        .wbwe       (wb_we),
        .sel        (wb_sel),
        .adr        (wb_adr),
        .dat_w      (wb_dat_w),
        .ack        (wb_ack),
        .dat_r      (wb_dat_r)
    );

    csr_file csr_file_i (
        .clk        (clk),
        .rst        (rst),
        .csr_addr   (csr_addr),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .csr_exists (csr_exists),
        .csr_rdonly (csr_rdonly)
    );

    // Only the low word-address bits reach the RAM, so addresses wrap.
    wb_ram #(
        .ADDR_WIDTH (`MEM_RAM_AW),
        .WAIT_STATES(`MEM_WAIT_STATES)
    ) wb_ram_i (
        .clk   (clk),
        .rst   (rst),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .we    (wb_we),
        .sel   (wb_sel),
        .adr   (wb_adr[`MEM_RAM_AW+1:2]),
        .dat_w (wb_dat_w),
        .ack   (wb_ack),
        .dat_r (wb_dat_r)
    );

endmodule

// ==== verif/tb_mem_subsys.sv ====
// Memory stage subsystem testbench
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys import mem_pkg::*; ();

    localparam int WS            = `MEM_WAIT_STATES;
    localparam int MEM_BYTES     = 4 << `MEM_RAM_AW;
    localparam int RANDOM_OPS    = 200;
    localparam int FILL_WORDS    = 16;
    localparam int DIRECTED_INSN = 70;
    localparam int MAX_CYCLES    = 8 * (WS + 3) * (DIRECTED_INSN + FILL_WORDS + RANDOM_OPS);
    localparam int RESP_LIMIT    = 4 * (WS + 3);
    localparam logic [31:0] FILL_BASE = 32'h0000_0200;

    // RV32 major opcodes.
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_LB     = 3'b000;
    localparam logic [2:0] F3_LH     = 3'b001;
    localparam logic [2:0] F3_LW     = 3'b010;
    localparam logic [2:0] F3_LBU    = 3'b100;
    localparam logic [2:0] F3_LHU    = 3'b101;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    logic        clk;
    logic        rst;
    logic        clear;
    logic        d_valid;
    logic [31:1] d_pc;
    logic [31:0] d_insn;
    logic        d_use_rd;
    logic [31:0] d_rs1_val;
    logic [31:0] d_rs2_val;
    logic        d_trap;
    logic [3:0]  d_cause;
    logic        q_valid;
    logic [31:1] q_pc;
    logic [31:0] q_insn;
    logic        q_use_rd;
    logic [31:0] q_rd_val;
    logic        q_trap;
    logic [3:0]  q_cause;
    logic        stall_req;

    int          checks = 0;
    int          errors = 0;
    int          missing = 0;
    int          cycles = 0;
    logic [31:0] lcg_state;
    logic [31:0] pc;

    // Shadow models of the RAM and the writable CSRs.
    logic [7:0]  shadow [MEM_BYTES];
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mtvec;

    mem_subsys mem_subsys_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .d_valid   (d_valid),
        .d_pc      (d_pc),
        .d_insn    (d_insn),
        .d_use_rd  (d_use_rd),
        .d_rs1_val (d_rs1_val),
        .d_rs2_val (d_rs2_val),
        .d_trap    (d_trap),
        .d_cause   (d_cause),
        .q_valid   (q_valid),
        .q_pc      (q_pc),
        .q_insn    (q_insn),
        .q_use_rd  (q_use_rd),
        .q_rd_val  (q_rd_val),
        .q_trap    (q_trap),
        .q_cause   (q_cause),
        .stall_req (stall_req)
    );

    always #5 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rs1, input logic [11:0] imm,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Byte index into the shadow, wrapping like the RAM.
    function automatic int idx(input logic [31:0] a);
        return int'(a & 32'(MEM_BYTES - 1));
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cause(input trap_cause_e got, input trap_cause_e exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Issues one instruction and checks its MEM/WB result.
    task automatic issue(input logic [31:0] insn, input logic [31:0] rs1v,
                         input logic [31:0] rs2v, input logic up_trap,
                         input logic [3:0] up_cause, input logic exp_trap,
                         input logic [3:0] exp_cause, input logic [31:0] exp_val,
                         input int exp_lat);
        int   lat;
        logic seen;
        while (stall_req) begin
            @(posedge clk);
            #1;
        end
        d_valid   = 1'b1;
        d_pc      = pc[31:1];
        d_insn    = insn;
        d_use_rd  = insn[11:7] != 5'd0;
        d_rs1_val = rs1v;
        d_rs2_val = rs2v;
        d_trap    = up_trap;
        d_cause   = up_cause;
        @(posedge clk);
        #1;
        d_valid = 1'b0;
        d_trap  = 1'b0;
        lat     = 0;
        seen    = 1'b0;
        while (!seen && lat < RESP_LIMIT) begin
            @(negedge clk);
            lat++;
            if (q_valid || q_trap) begin
                seen = 1'b1;
            end else begin
                check_flag(stall_req, 1'b1, "stall_req while waiting");
            end
        end
        if (!seen) begin
            missing++;
            $display("No result came back within %0d cycles for instruction %h",
                     RESP_LIMIT, insn);
        end else begin
            check_flag(q_valid, !exp_trap, "q_valid");
            check_flag(q_trap, exp_trap, "q_trap");
            if (exp_trap) begin
                check_cause(trap_cause_e'(q_cause), trap_cause_e'(exp_cause), "q_cause");
            end else begin
                check_word(q_rd_val, exp_val, "q_rd_val");
            end
            check_word({q_pc, 1'b0}, pc, "q_pc");
            check_word(q_insn, insn, "q_insn");
            check_flag(q_use_rd, insn[11:7] != 5'd0, "q_use_rd");
            check_flag(stall_req, 1'b0, "stall_req with result");
            check_word(32'(lat), 32'(exp_lat), "result latency");
            @(negedge clk);
            check_flag(q_valid | q_trap, 1'b0, "result held past one cycle");
        end
        pc = pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic alu(input logic [6:0] opc, input logic [31:0] val, input logic [4:0] rd);
        issue(encode(opc, 3'b000, 5'd3, 12'h055, rd), val, lcg_next(), 1'b0, 4'd0,
              1'b0, 4'd0, val, 1);
    endtask

    // Aligned store; the shadow takes the low bytes of data.
    task automatic store(input logic [1:0] size, input logic [31:0] addr,
                         input logic [31:0] data);
        issue(encode(OPC_STORE, {1'b0, size}, 5'd2, 12'd0, 5'd0), addr, data, 1'b0, 4'd0,
              1'b0, 4'd0, addr, WS + 1);
        for (int i = 0; i < (1 << size); i++) begin
            shadow[idx(addr + 32'(i))] = data[8*i +: 8];
        end
    endtask

    task automatic load(input logic [2:0] f3, input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] exp;
        b = shadow[idx(addr)];
        h = {shadow[idx(addr + 32'd1)], b};
        case (f3)
            F3_LB:   exp = {{24{b[7]}}, b};
            F3_LH:   exp = {{16{h[15]}}, h};
            F3_LBU:  exp = {24'd0, b};
            F3_LHU:  exp = {16'd0, h};
            default: exp = {shadow[idx(addr + 32'd3)], shadow[idx(addr + 32'd2)], h};
        endcase
        issue(encode(OPC_LOAD, f3, 5'd1, 12'd0, 5'd10), addr, 32'd0, 1'b0, 4'd0,
              1'b0, 4'd0, exp, WS + 1);
    endtask

    task automatic misaligned(input logic is_st, input logic [2:0] f3, input logic [31:0] addr);
        issue(encode(is_st ? OPC_STORE : OPC_LOAD, f3, 5'd1, 12'd0, is_st ? 5'd0 : 5'd9),
              addr, 32'hDEAD_BEEF, 1'b0, 4'd0, 1'b1, is_st ? 4'd6 : 4'd4, 32'd0, 1);
    endtask

    // CSR instruction against the shadow CSR model.
    task automatic csr_op(input logic [2:0] f3, input logic [11:0] csr,
                          input logic [4:0] field, input logic [31:0] rs1v);
        logic        known;
        logic        fixed;
        logic        wr;
        logic        bad;
        logic [31:0] old;
        logic [31:0] operand;
        logic [31:0] nval;
        known = 1'b1;
        fixed = 1'b0;
        old   = 32'd0;
        if (csr == `CSR_MSCRATCH) begin
            old = sh_mscratch;
        end else if (csr == `CSR_MTVEC) begin
            old = sh_mtvec;
        end else if (csr == `CSR_MHARTID || csr == `CSR_MISA) begin
            old   = (csr == `CSR_MISA) ? `MISA_VALUE : `MHARTID_VALUE;
            fixed = 1'b1;
        end else begin
            known = 1'b0;
        end
        operand = f3[2] ? {27'd0, field} : rs1v;
        wr      = (f3[1:0] == 2'b01) || (field != 5'd0);
        bad     = !known || (wr && fixed);
        if (!bad && wr) begin
            if (f3[1:0] == 2'b01) begin
                nval = operand;
            end else if (f3[1:0] == 2'b10) begin
                nval = old | operand;
            end else begin
                nval = old & ~operand;
            end
            if (csr == `CSR_MSCRATCH) begin
                sh_mscratch = nval;
            end else begin
                sh_mtvec = {nval[31:2], 2'b00};
            end
        end
        issue(encode(OPC_SYSTEM, f3, field, csr, 5'd11), rs1v, 32'd0, 1'b0, 4'd0,
              bad, 4'd2, old, 1);
    endtask

    // Captures an instruction, then clears the stage after delay cycles.
    task automatic squash(input logic [31:0] insn, input logic [31:0] rs1v,
                          input logic [31:0] rs2v, input int delay);
        d_valid   = 1'b1;
        d_pc      = pc[31:1];
        d_insn    = insn;
        d_use_rd  = insn[11:7] != 5'd0;
        d_rs1_val = rs1v;
        d_rs2_val = rs2v;
        @(posedge clk);
        #1;
        d_valid = 1'b0;
        for (int n = 0; n < delay; n++) begin
            @(negedge clk);
            check_flag(q_valid | q_trap, 1'b0, "result before clear");
            @(posedge clk);
            #1;
        end
        clear = 1'b1;
        for (int n = 0; n < WS + 3; n++) begin
            @(negedge clk);
            check_flag(q_valid | q_trap, 1'b0, "result of a cleared instruction");
            @(posedge clk);
            #1;
            clear = 1'b0;
        end
        check_flag(stall_req, 1'b0, "stall_req after clear");
        pc = pc + 32'd4;
    endtask

    task automatic test_alu();
        alu(OPC_IMM, 32'h1234_5678, 5'd5);
        alu(OPC_REG, 32'hFFFF_0000, 5'd0);
        alu(OPC_LUI, 32'hABCD_E000, 5'd31);
        alu(OPC_IMM, lcg_next(), 5'd7);
    endtask

    task automatic test_sized();
        store(2'd2, 32'h000, 32'h8081_F27F);
        store(2'd2, 32'h004, 32'h1122_3344);
        store(2'd2, 32'h008, 32'hCAFE_0001);
        store(2'd2, 32'h00C, 32'h0000_0000);
        store(2'd1, 32'h006, 32'h0000_9A5C);
        store(2'd1, 32'h00C, 32'hFFFF_7EEF);
        store(2'd0, 32'h009, 32'h0000_00A5);
        store(2'd0, 32'h00F, 32'h0000_0080);
        store(2'd0, 32'h00D, 32'hFFFF_FF01);
        for (int a = 0; a < 16; a += 4) begin
            load(F3_LW, 32'(a));
        end
        load(F3_LH, 32'h000);
        load(F3_LH, 32'h002);
        load(F3_LHU, 32'h002);
        load(F3_LH, 32'h006);
        load(F3_LHU, 32'h00C);
        for (int a = 0; a < 4; a++) begin
            load(F3_LB, 32'(a));
            load(F3_LBU, 32'(a));
        end
        load(F3_LB, 32'h009);
        load(F3_LB, 32'h00F);
        load(F3_LBU, 32'h00F);
    endtask

    task automatic test_misalign();
        misaligned(1'b0, F3_LH, 32'h001);
        misaligned(1'b0, F3_LHU, 32'h005);
        misaligned(1'b0, F3_LW, 32'h002);
        misaligned(1'b0, F3_LW, 32'h003);
        misaligned(1'b1, F3_LH, 32'h003);
        misaligned(1'b1, F3_LW, 32'h006);
        // Size code 3 is an illegal instruction, not a misalignment.
        issue(encode(OPC_LOAD, 3'b011, 5'd1, 12'd0, 5'd9), 32'h0, 32'h0, 1'b0, 4'd0,
              1'b1, 4'd2, 32'd0, 1);
        load(F3_LW, 32'h000);
        load(F3_LW, 32'h004);
    endtask

    task automatic test_csr();
        csr_op(F3_CSRRW, `CSR_MSCRATCH, 5'd5, 32'hA5A5_0F0F);
        csr_op(F3_CSRRS, `CSR_MSCRATCH, 5'd6, 32'h0000_F000);
        csr_op(F3_CSRRC, `CSR_MSCRATCH, 5'd7, 32'hA500_0000);
        csr_op(F3_CSRRWI, `CSR_MSCRATCH, 5'd21, 32'hFFFF_FFFF);
        csr_op(F3_CSRRSI, `CSR_MSCRATCH, 5'd10, 32'd0);
        csr_op(F3_CSRRCI, `CSR_MSCRATCH, 5'd3, 32'd0);
        csr_op(F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF);
        csr_op(F3_CSRRCI, `CSR_MSCRATCH, 5'd0, 32'd0);
        csr_op(F3_CSRRW, `CSR_MTVEC, 5'd8, 32'h8000_0103);
        csr_op(F3_CSRRS, `CSR_MTVEC, 5'd0, 32'd0);
        csr_op(F3_CSRRS, `CSR_MHARTID, 5'd0, 32'd0);
        csr_op(F3_CSRRS, `CSR_MISA, 5'd0, 32'd0);
        // Faults below leave both CSRs alone.
        csr_op(F3_CSRRW, `CSR_MHARTID, 5'd4, 32'h0000_0001);
        csr_op(F3_CSRRSI, `CSR_MISA, 5'd1, 32'd0);
        csr_op(F3_CSRRS, 12'h7C0, 5'd0, 32'd0);
        csr_op(F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'd0);
        csr_op(F3_CSRRS, `CSR_MTVEC, 5'd0, 32'd0);
    endtask

    task automatic test_trap_clear();
        issue(encode(OPC_STORE, F3_LW, 5'd2, 12'd0, 5'd0), 32'h004, 32'hFFFF_FFFF,
              1'b1, 4'd1, 1'b1, 4'd1, 32'd0, 1);
        issue(encode(OPC_IMM, 3'b000, 5'd3, 12'h001, 5'd4), 32'h55, 32'h0,
              1'b1, 4'd12, 1'b1, 4'd12, 32'd0, 1);
        load(F3_LW, 32'h004);
        squash(encode(OPC_STORE, F3_LW, 5'd2, 12'd0, 5'd0), 32'h008, 32'h7777_7777, 1);
        squash(encode(OPC_STORE, F3_LW, 5'd2, 12'd0, 5'd0), 32'h008, 32'h6666_6666, 0);
        load(F3_LW, 32'h008);
        squash(encode(OPC_SYSTEM, F3_CSRRW, 5'd5, `CSR_MSCRATCH, 5'd11), 32'h1357, 32'h0, 0);
        csr_op(F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'd0);
    endtask

    // Aligned loads, stores and ALU ops in a prefilled window.
    task automatic test_random();
        logic [31:0] r;
        logic [1:0]  size;
        logic [5:0]  off;
        for (int i = 0; i < FILL_WORDS; i++) begin
            store(2'd2, FILL_BASE + 32'(4 * i), lcg_next());
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r    = lcg_next();
            size = (r[21:20] == 2'd3) ? 2'd2 : r[21:20];
            case (size)
                2'd0:    off = r[29:24];
                2'd1:    off = {r[29:25], 1'b0};
                default: off = {r[29:26], 2'b00};
            endcase
            case (r[17:16])
                2'd0:    alu(OPC_IMM, lcg_next(), r[12:8]);
                2'd1:    store(size, FILL_BASE + 32'(off), lcg_next());
                default: load({r[22] & (size != 2'd2), size}, FILL_BASE + 32'(off));
            endcase
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        clear       = 1'b0;
        d_valid     = 1'b0;
        d_pc        = '0;
        d_insn      = '0;
        d_use_rd    = 1'b0;
        d_rs1_val   = '0;
        d_rs2_val   = '0;
        d_trap      = 1'b0;
        d_cause     = '0;
        lcg_state   = 32'h14e;
        pc          = 32'h0000_1000;
        sh_mscratch = 32'd0;
        sh_mtvec    = 32'd0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag(q_valid | q_trap | stall_req, 1'b0, "outputs after reset");
        @(posedge clk);
        #1;
        test_alu();
        test_sized();
        test_misalign();
        test_csr();
        test_trap_clear();
        test_random();
        $display("Checks: %0d, value errors: %0d, missing results: %0d",
                 checks, errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/mem_pkg.sv
src/csr_file.sv
src/lsu_wb.sv
src/wb_ram.sv
src/mem_stage.sv
src/mem_subsys.sv
verif/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, LOG, BUILD_DIR, VFLAGS"

$(BUILD_DIR)/V$(TOP): sources.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f sources.f

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
